// ==== filelist.f ====
+incdir+.
vic_bus_pkg.sv
phase_counter.sv
bus_sequencer.sv
register_file.sv
fetch_engine.sv
vic_bus_top.sv
vic_bus_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing -Wno-fatal
TOP       ?= vic_bus_tb
FILELIST  ?= filelist.f
PASS_STR  := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_STR)'

clean:
	rm -rf obj_dir

// ==== vic_bus_tb.sv ====
// ************************************************
// vic bus testbench
// directed tests with a flat memory model on the
// shared bus, checks timing, registers and fetches
// ************************************************
`timescale 1ns/1ns
`default_nettype none

`include "vic_bus_macros.svh"

module vic_bus_tb;

  logic        clk_col4x_pal = 1'b0;
  logic        arst_n;
  logic        ce;
  logic        rw;
  logic        cpu_en;       // tb owns adl in cpu halves
  logic        cpu_wr;       // tb owns dbl in cpu halves
  logic [5:0]  cpu_adl;
  logic [7:0]  cpu_dbl;
  tri   [5:0]  adl;
  tri   [5:0]  adh;
  tri   [7:0]  dbl;
  wire  [3:0]  dbh;
  wire         phi;
  wire         ba;
  wire         aec;
  wire  [7:0]  gfx_pixels;
  wire  [3:0]  gfx_color;
  wire         gfx_valid;
  logic [7:0]  mem [4096];   // video memory seen by the vic
  wire  [11:0] bus_addr = {adh, adl};
  logic [1:0]  vm_sel;
  logic        cb_sel;

  vic_bus_top UUT (
    .clk_col4x_pal(clk_col4x_pal), .arst_n(arst_n), .ce(ce), .rw(rw),
    .adl(adl), .adh(adh), .dbl(dbl), .dbh(dbh), .phi(phi), .ba(ba), .aec(aec),
    .gfx_pixels(gfx_pixels), .gfx_color(gfx_color), .gfx_valid(gfx_valid)
  );

  always #4 clk_col4x_pal = ~clk_col4x_pal;

  // memory answers only while the vic holds the bus
  assign dbl = !aec ? mem[bus_addr] : ((cpu_en && cpu_wr) ? cpu_dbl : 8'bz);
  assign dbh = !aec ? bus_addr[3:0] : 4'h0;  // colour ram follows the address
  assign adl = (cpu_en && aec) ? cpu_adl : 6'bz;

  task automatic fail_stop(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
      fail_stop($sformatf("FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp));
  endtask

  task automatic check_nibble(input string name, input logic [3:0] got,
                              input logic [3:0] exp);
    if (got !== exp)
      fail_stop($sformatf("FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_stop($sformatf("FAILED t=%0t %s got=%b exp=%b", $time, name, got, exp));
  endtask

  // sampled on the falling clock, away from the driving edge
  task automatic wait_phi(input logic level);
    int n;
    n = 0;
    do begin
      @(negedge clk_col4x_pal);
      n++;
      if (n > 16) fail_stop("phi stopped toggling");
    end while (phi !== level);
  endtask

  // one cpu bus cycle in the next phi high half
  task automatic cpu_access(input logic wr, input logic [5:0] addr, input logic [7:0] wdata,
                            output logic [7:0] rdata);
    int n;
    n = 0;
    rdata = 8'hxx;
    wait_phi(1'b0);
    wait_phi(1'b1);
    @(posedge clk_col4x_pal);
    ce      <= 1'b0;
    rw      <= !wr;
    cpu_adl <= addr;
    cpu_dbl <= wdata;
    cpu_wr  <= wr;
    cpu_en  <= 1'b1;
    do begin
      @(negedge clk_col4x_pal);
      if (phi) rdata = dbl;  // last high sample wins
      n++;
      if (n > 8) fail_stop("cpu half never ended");
    end while (phi);
    @(posedge clk_col4x_pal);
    ce     <= 1'b1;
    rw     <= 1'b1;
    cpu_wr <= 1'b0;
    cpu_en <= 1'b0;
  endtask

  task automatic reset_state_test;
    @(negedge clk_col4x_pal);
    check_bit("ba", ba, 1'b1);
    check_bit("aec", aec, 1'b1);
    check_bit("phi", phi, 1'b0);
    check_bit("gfx_valid", gfx_valid, 1'b0);
    check_byte("adl", {2'b00, adl}, {2'b00, 6'bzz_zzzz});
    check_byte("adh", {2'b00, adh}, {2'b00, 6'bzz_zzzz});
    check_byte("dbl", dbl, 8'bzzzz_zzzz);
  endtask

  task automatic timing_test;
    logic [7:0] highs;
    logic [7:0] lows;
    int n;
    highs = 8'd1;
    lows  = 8'd0;
    wait_phi(1'b0);
    wait_phi(1'b1);
    for (n = 0; n < 20 && phi; n++) begin
      @(negedge clk_col4x_pal);
      if (phi) highs++;
    end
    for (n = 0; n < 20 && !phi; n++) begin
      lows++;
      @(negedge clk_col4x_pal);
    end
    check_byte("phi high clocks", highs, 8'd4);
    check_byte("phi low clocks", lows, 8'd4);
    // den is clear, a whole frame must stay quiet
    for (n = 0; n < `VIC_LINES_PER_FRAME * `VIC_CYCLES_PER_LINE * 8; n++) begin
      @(negedge clk_col4x_pal);
      check_bit("ba", ba, 1'b1);
      check_bit("gfx_valid", gfx_valid, 1'b0);
    end
  endtask

  task automatic register_test;
    logic [7:0] wval;
    logic [7:0] rval;
    logic [7:0] first;
    wval = 8'($urandom);
    cpu_access(1'b1, `VIC_REG_MEMPTR, wval, rval);
    cpu_access(1'b0, `VIC_REG_MEMPTR, 8'h00, rval);
    check_byte("memptr", rval, wval);
    wval = 8'($urandom);
    cpu_access(1'b1, `VIC_REG_BORDER, wval, rval);
    cpu_access(1'b0, `VIC_REG_BORDER, 8'h00, rval);
    check_byte("border", rval, {4'hf, wval[3:0]});
    cpu_access(1'b0, 6'h3f, 8'h00, rval);
    check_byte("unused reg", rval, 8'hff);
    cpu_access(1'b0, `VIC_REG_RASTER, 8'h00, first);
    repeat (`VIC_CYCLES_PER_LINE * 8) @(negedge clk_col4x_pal);  // exactly one line
    cpu_access(1'b0, `VIC_REG_RASTER, 8'h00, rval);
    check_byte("raster", rval, first + 8'd1);
  endtask

  // ba lead and c-access count on the first badline
  task automatic arbitration_check;
    logic [7:0] rises;
    logic [7:0] lead;
    logic [7:0] c_count;
    logic       prev_phi;
    logic       cond;
    logic       prev_cond;
    int n;
    rises     = 8'd0;
    lead      = 8'd0;
    c_count   = 8'd0;
    prev_phi  = phi;
    prev_cond = 1'b0;
    for (n = 0; n < `VIC_CYCLES_PER_LINE * 8 && !ba; n++) begin
      @(negedge clk_col4x_pal);
      if (phi && !prev_phi) rises++;
      cond = phi && prev_phi && !aec;  // aec still low deep into phi high
      if (cond && !prev_cond) begin
        if (c_count == 8'd0) lead = rises - 8'd1;
        c_count++;
      end
      prev_cond = cond;
      prev_phi  = phi;
    end
    if (!ba) fail_stop("ba never returned high after the badline");
    check_byte("ba lead cycles", lead, 8'(`VIC_BA_LEAD));
    check_byte("c-access count", c_count, 8'd40);
  endtask

  task automatic gfx_check;
    logic [7:0]  idx;
    logic [7:0]  chr;
    logic [11:0] c_addr;
    logic [11:0] g_addr;
    int n;
    idx = 8'd0;
    for (n = 0; n < `VIC_CYCLES_PER_LINE * 8; n++) begin
      @(negedge clk_col4x_pal);
      if (gfx_valid) begin
        if (idx >= 8'd40) fail_stop("more than 40 graphics strobes in one line");
        c_addr = {vm_sel, 10'(idx)};        // vm_base * 1024 + vc, row 0
        chr    = mem[c_addr];
        g_addr = {cb_sel, chr, 3'd0};       // rc is 0 on the badline itself
        check_byte("gfx_pixels", gfx_pixels, mem[g_addr]);
        check_nibble("gfx_color", gfx_color, c_addr[3:0]);
        idx++;
      end
    end
    check_byte("gfx strobes", idx, 8'd40);
  endtask

  task automatic badline_test;
    logic [7:0] mptr;
    logic [7:0] rval;
    logic [2:0] ys;
    int n;
    mptr   = 8'($urandom);
    ys     = 3'($urandom);
    vm_sel = mptr[5:4];
    cb_sel = mptr[1];
    cpu_access(1'b1, `VIC_REG_MEMPTR, mptr, rval);
    cpu_access(1'b1, `VIC_REG_CTRL, {5'b00010, ys}, rval);  // den plus yscroll
    n = 0;
    do begin
      @(negedge clk_col4x_pal);
      n++;
      if (n > 2 * `VIC_LINES_PER_FRAME * `VIC_CYCLES_PER_LINE * 8)
        fail_stop("no badline seen with den set");
    end while (ba);
    fork
      arbitration_check();
      gfx_check();
    join
  endtask

  initial begin
    int i;
    void'($urandom(32'h0ab4_5cbf));
    for (i = 0; i < 4096; i++) mem[i] = 8'($urandom);
    arst_n  = 1'b0;
    ce      = 1'b1;
    rw      = 1'b1;
    cpu_en  = 1'b0;
    cpu_wr  = 1'b0;
    cpu_adl = 6'd0;
    cpu_dbl = 8'd0;
    vm_sel  = 2'd0;
    cb_sel  = 1'b0;
    repeat (16) @(posedge clk_col4x_pal);
    arst_n <= 1'b1;
    reset_state_test();
    timing_test();
    register_test();
    badline_test();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vic_bus_top.sv ====
// ************************************************
// vic bus top
// ties the four blocks together and drives the
// shared address and data buses
// ************************************************
`timescale 1ns/1ns
`default_nettype none

module vic_bus_top (
  input  wire       clk_col4x_pal,
  input  wire       arst_n,
  input  wire       ce,          // low selects the chip
  input  wire       rw,          // low is a cpu write
  inout  tri  [5:0] adl,
  output tri  [5:0] adh,
  inout  tri  [7:0] dbl,
  input  wire [3:0] dbh,         // colour ram nibble
  output wire       phi,
  output wire       ba,
  output wire       aec,
  output wire [7:0] gfx_pixels,
  output wire [3:0] gfx_color,
  output wire       gfx_valid
);

  import vic_bus_pkg::*;

  wire        phi_fall;
  wire        phi_rise;
  wire        phi_end;
  wire [5:0]  cycle;
  wire [8:0]  raster;
  bus_phase_t cur_phase;
  wire        fetch_g;
  wire        fetch_c;
  wire        badline;
  wire        den;
  wire [2:0]  yscroll;
  wire [1:0]  vm_base;
  wire        cb_base;
  wire [7:0]  reg_dout;
  wire        vic_write_db;
  wire [11:0] ado;
  wire        vic_write_ab;

  phase_counter u_phase (
    .clk_col4x_pal(clk_col4x_pal), .arst_n(arst_n),
    .phi(phi), .phi_fall(phi_fall), .phi_rise(phi_rise), .phi_end(phi_end),
    .cycle(cycle), .raster(raster)
  );

  bus_sequencer u_seq (
    .clk_col4x_pal(clk_col4x_pal), .arst_n(arst_n),
    .phi_fall(phi_fall), .phi_rise(phi_rise), .cycle(cycle), .raster(raster),
    .den(den), .yscroll(yscroll), .ba(ba), .aec(aec), .cur_phase(cur_phase),
    .fetch_g(fetch_g), .fetch_c(fetch_c), .badline(badline)
  );

  register_file u_regs (
    .clk_col4x_pal(clk_col4x_pal), .arst_n(arst_n), .phi_end(phi_end),
    .cur_phase(cur_phase), .ce(ce), .rw(rw), .reg_addr(adl), .reg_din(dbl),
    .raster(raster), .reg_dout(reg_dout), .vic_write_db(vic_write_db),
    .den(den), .yscroll(yscroll), .vm_base(vm_base), .cb_base(cb_base)
  );

  fetch_engine u_fetch (
    .clk_col4x_pal(clk_col4x_pal), .arst_n(arst_n), .phi_end(phi_end),
    .fetch_g(fetch_g), .fetch_c(fetch_c), .badline(badline), .cycle(cycle),
    .raster(raster), .yscroll(yscroll), .vm_base(vm_base), .cb_base(cb_base),
    .dbi({dbh, dbl}), .ado(ado), .vic_write_ab(vic_write_ab),
    .gfx_pixels(gfx_pixels), .gfx_color(gfx_color), .gfx_valid(gfx_valid)
  );

  // vic drives a bus only while it owns it, else it floats
  assign dbl = vic_write_db ? reg_dout : 8'bz;   // cpu register read
  assign adl = vic_write_ab ? ado[5:0] : 6'bz;   // c or g fetch
  assign adh = vic_write_ab ? ado[11:6] : 6'bz;

endmodule

`default_nettype wire

// ==== fetch_engine.sv ====
// ************************************************
// fetch engine
// video counters, c/g address generation, the
// 40 entry line buffer and the graphics output
// ************************************************
`timescale 1ns/1ns
`default_nettype none

`include "vic_bus_macros.svh"

module fetch_engine (
  input  wire         clk_col4x_pal,
  input  wire         arst_n,
  input  wire         phi_end,
  input  wire         fetch_g,
  input  wire         fetch_c,
  input  wire         badline,
  input  wire  [5:0]  cycle,
  input  wire  [8:0]  raster,
  input  wire  [2:0]  yscroll,
  input  wire  [1:0]  vm_base,
  input  wire         cb_base,
  input  wire  [11:0] dbi,
  output logic [11:0] ado,
  output logic        vic_write_ab,
  output logic [7:0]  gfx_pixels,
  output logic [3:0]  gfx_color,
  output logic        gfx_valid
);

  import vic_bus_pkg::*;

  localparam logic [5:0] VC_LOAD_CYCLE = 6'(`VIC_FETCH_FIRST - 1);
  localparam logic [5:0] ROW_END_CYCLE = 6'd58;
  localparam logic [1:0] HOLD_CLKS     = 2'd2;  // strobe is one clock into the half

  fetch_word_t line_buf [40];  // c-access results for the current row
  fetch_word_t dbi_word;
  fetch_word_t buf_rd;

  logic [9:0] vc;
  logic [9:0] vc_base;
  logic [5:0] vmli;        // line buffer index
  logic [2:0] rc;          // row within the character
  logic       row_active;  // a badline has opened a text row
  logic [1:0] hold_cnt;    // clocks left on the address bus
  logic       fetch_is_g;
  logic       sample;      // last clock of the access half

  assign dbi_word = dbi;
  assign buf_rd   = line_buf[vmli];
  assign rc       = raster[2:0] - yscroll;
  assign sample   = (hold_cnt == 2'd1);

  always_ff @(posedge clk_col4x_pal or negedge arst_n) begin
    if (!arst_n) begin
      vic_write_ab <= 1'b0;
      hold_cnt     <= 2'd0;
      fetch_is_g   <= 1'b0;
      gfx_valid    <= 1'b0;
      vc           <= 10'd0;
      vc_base      <= 10'd0;
      vmli         <= 6'd0;
      row_active   <= 1'b0;
    end else begin
      gfx_valid <= sample && fetch_is_g;  // one clock after the pixel sample
      if (fetch_g || fetch_c) begin
        vic_write_ab <= 1'b1;
        hold_cnt     <= HOLD_CLKS;
        fetch_is_g   <= fetch_g;
      end else if (hold_cnt != 2'd0) begin
        hold_cnt <= hold_cnt - 2'd1;
        if (sample) begin
          vic_write_ab <= 1'b0;  // release adl/adh
        end
      end
      if (sample && fetch_is_g) begin
        vc   <= vc + 10'd1;
        vmli <= vmli + 6'd1;
      end
      if (phi_end) begin
        if (cycle == VC_LOAD_CYCLE) begin
          vc   <= vc_base;
          vmli <= 6'd0;
          if (badline) row_active <= 1'b1;
        end
        if (cycle == ROW_END_CYCLE && rc == 3'd7 && row_active) begin
          vc_base <= vc;  // move on to the next text row
        end
        if (raster == 9'd0) begin
          vc_base    <= 10'd0;  // top of frame
          row_active <= 1'b0;
        end
      end
    end
  end

  // address, buffer and pixel payload
  always_ff @(posedge clk_col4x_pal) begin
    if (fetch_c) begin
      ado <= {vm_base, vc};  // video matrix
    end else if (fetch_g) begin
      ado <= {cb_base, buf_rd.c.char_code, rc};  // character generator
    end
    if (sample && !fetch_is_g) begin
      line_buf[vmli] <= dbi_word;  // colour and screen code
    end
    if (sample && fetch_is_g) begin
      gfx_pixels <= dbi_word.g.pixels;
      gfx_color  <= buf_rd.c.color;
    end
  end

endmodule

`default_nettype wire

// ==== register_file.sv ====
// ************************************************
// register file
// cpu visible control, memory pointer and border
// registers with read mux and data bus enable
// ************************************************
`timescale 1ns/1ns
`default_nettype none

`include "vic_bus_macros.svh"

module register_file (
  input  wire                     clk_col4x_pal,
  input  wire                     arst_n,
  input  wire                     phi_end,
  input  vic_bus_pkg::bus_phase_t cur_phase,
  input  wire                     ce,
  input  wire                     rw,
  input  wire  [5:0]              reg_addr,
  input  wire  [7:0]              reg_din,
  input  wire  [8:0]              raster,
  output logic [7:0]              reg_dout,
  output logic                    vic_write_db,
  output logic                    den,
  output logic [2:0]              yscroll,
  output logic [1:0]              vm_base,
  output logic                    cb_base
);

  import vic_bus_pkg::*;

  localparam logic [5:0] ADDR_CTRL   = 6'(`VIC_REG_CTRL);
  localparam logic [5:0] ADDR_RASTER = 6'(`VIC_REG_RASTER);
  localparam logic [5:0] ADDR_MEMPTR = 6'(`VIC_REG_MEMPTR);
  localparam logic [5:0] ADDR_BORDER = 6'(`VIC_REG_BORDER);

  logic [6:0] ctrl_reg;    // bit 7 is raster bit 8 on reads
  logic [7:0] memptr_reg;
  logic [3:0] border_reg;
  logic       cpu_sel;     // cpu half with chip selected

  assign cpu_sel = (cur_phase == phase_cpu) && !ce;

  // writes land at the end of the cpu half
  always_ff @(posedge clk_col4x_pal or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_reg   <= 7'd0;
      memptr_reg <= 8'd0;
      border_reg <= 4'd0;
    end else if (phi_end && cpu_sel && !rw) begin
      case (reg_addr)
        ADDR_CTRL:   ctrl_reg   <= reg_din[6:0];
        ADDR_MEMPTR: memptr_reg <= reg_din;
        ADDR_BORDER: border_reg <= reg_din[3:0];
        default:     ;  // raster compare and the rest are not kept
      endcase
    end
  end

  always_comb begin
    case (reg_addr)
      ADDR_CTRL:   reg_dout = {raster[8], ctrl_reg};
      ADDR_RASTER: reg_dout = raster[7:0];
      ADDR_MEMPTR: reg_dout = memptr_reg;
      ADDR_BORDER: reg_dout = {4'hf, border_reg};  // unused nibble reads high
      default:     reg_dout = 8'hff;
    endcase
  end

  assign vic_write_db = cpu_sel && rw;  // drive dbl for the read half

  assign yscroll = ctrl_reg[2:0];
  assign den     = ctrl_reg[4];
  assign vm_base = memptr_reg[5:4];  // only the low two matrix bits exist
  assign cb_base = memptr_reg[1];    // low character base bit

endmodule

`default_nettype wire

// ==== bus_sequencer.sv ====
// ************************************************
// bus sequencer
// badline detection, ba/aec arbitration and the
// owner of each phi half-cycle
// ************************************************
`timescale 1ns/1ns
`default_nettype none

`include "vic_bus_macros.svh"

module bus_sequencer (
  input  wire                     clk_col4x_pal,
  input  wire                     arst_n,
  input  wire                     phi_fall,
  input  wire                     phi_rise,
  input  wire  [5:0]              cycle,
  input  wire  [8:0]              raster,
  input  wire                     den,
  input  wire  [2:0]              yscroll,
  output logic                    ba,
  output logic                    aec,
  output vic_bus_pkg::bus_phase_t cur_phase,
  output logic                    fetch_g,
  output logic                    fetch_c,
  output logic                    badline
);

  import vic_bus_pkg::*;

  localparam logic [5:0] BA_FIRST = 6'(`VIC_FETCH_FIRST - `VIC_BA_LEAD);
  localparam logic [5:0] C_FIRST  = 6'(`VIC_FETCH_FIRST);
  localparam logic [5:0] C_LAST   = 6'(`VIC_FETCH_LAST);
  // g-access trails its c-access by one cycle so the character is already buffered
  localparam logic [5:0] G_FIRST  = 6'(`VIC_FETCH_FIRST + 1);
  localparam logic [5:0] G_LAST   = 6'(`VIC_FETCH_LAST + 1);
  localparam logic [8:0] DMA_FIRST = 9'(`VIC_FIRST_DMA_LINE);
  localparam logic [8:0] DMA_LAST  = 9'(`VIC_LAST_DMA_LINE);

  logic dma_line;     // display window line with den set
  logic badline_now;  // badline condition on the current raster
  logic ba_window;
  logic c_window;
  logic g_window;

  assign dma_line    = den && (raster >= DMA_FIRST) && (raster <= DMA_LAST);
  assign badline_now = dma_line && (raster[2:0] == yscroll);

  assign ba_window = (cycle >= BA_FIRST) && (cycle <= C_LAST);
  assign c_window  = (cycle >= C_FIRST) && (cycle <= C_LAST);
  assign g_window  = (cycle >= G_FIRST) && (cycle <= G_LAST);

  always_ff @(posedge clk_col4x_pal or negedge arst_n) begin
    if (!arst_n) begin
      cur_phase <= phase_idle;
      ba        <= 1'b1;
      aec       <= 1'b1;
      fetch_g   <= 1'b0;
      fetch_c   <= 1'b0;
      badline   <= 1'b0;
    end else begin
      fetch_g <= 1'b0;  // strobes last one clock
      fetch_c <= 1'b0;
      if (phi_fall) begin
        if (cycle == 6'd0) begin
          badline <= badline_now;  // latched once per line
        end
        ba  <= !(badline && ba_window);
        aec <= 1'b0;  // phi low always belongs to the vic
        if (dma_line && g_window) begin
          cur_phase <= phase_g_access;
          fetch_g   <= 1'b1;
        end else begin
          cur_phase <= phase_idle;
        end
      end else if (phi_rise) begin
        if (badline && c_window) begin
          cur_phase <= phase_c_access;  // cpu is stalled by ba
          aec       <= 1'b0;
          fetch_c   <= 1'b1;
        end else begin
          cur_phase <= phase_cpu;
          aec       <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== phase_counter.sv ====
// ************************************************
// phase counter
// divides clk_col4x_pal into phi and counts the
// cycle within a line and the raster line
// ************************************************
`timescale 1ns/1ns
`default_nettype none

`include "vic_bus_macros.svh"

module phase_counter (
  input  wire        clk_col4x_pal,
  input  wire        arst_n,
  output logic       phi,
  output logic       phi_fall,
  output logic       phi_rise,
  output logic       phi_end,
  output logic [5:0] cycle,
  output logic [8:0] raster
);

  localparam logic [2:0] TICK_LAST   = 3'(`VIC_TICKS_PER_PHI - 1);
  localparam logic [2:0] TICK_HALF   = 3'(`VIC_TICKS_PER_PHI / 2);
  localparam logic [5:0] CYCLE_LAST  = 6'(`VIC_CYCLES_PER_LINE - 1);
  localparam logic [8:0] RASTER_LAST = 9'(`VIC_LINES_PER_FRAME - 1);

  logic [2:0] tick;  // position inside one phi cycle

  always_ff @(posedge clk_col4x_pal or negedge arst_n) begin
    if (!arst_n) begin
      tick   <= 3'd0;
      cycle  <= 6'd0;
      raster <= 9'd0;
    end else begin
      tick <= (tick == TICK_LAST) ? 3'd0 : tick + 3'd1;
      if (phi_end) begin
        if (cycle == CYCLE_LAST) begin
          cycle  <= 6'd0;
          raster <= (raster == RASTER_LAST) ? 9'd0 : raster + 9'd1;  // next line
        end else begin
          cycle <= cycle + 6'd1;
        end
      end
    end
  end

  // all strobes decode straight from tick
  assign phi      = (tick >= TICK_HALF);
  assign phi_fall = (tick == 3'd0);
  assign phi_rise = (tick == TICK_HALF);
  assign phi_end  = (tick == TICK_LAST);  // last clock of phi high

endmodule

`default_nettype wire

// ==== vic_bus_pkg.sv ====
// ************************************************
// vic bus types
// bus phase owner and the fetched data bus word
// ************************************************
`default_nettype none

package vic_bus_pkg;

  // who owns the current half-cycle
  typedef enum logic [1:0] {
    phase_idle     = 2'd0,  // phi low, nothing to fetch
    phase_g_access = 2'd1,  // phi low, graphics fetch
    phase_c_access = 2'd2,  // phi high, stolen from cpu
    phase_cpu      = 2'd3   // phi high, cpu owns the bus
  } bus_phase_t;

  // {dbh, dbl} as seen at the end of a fetch
  typedef union packed {
    // c-access, colour ram nibble plus screen code
    struct packed {
      logic [3:0] color;
      logic [7:0] char_code;
    } c;
    // g-access, dbh carries nothing useful
    struct packed {
      logic [3:0] unused;
      logic [7:0] pixels;
    } g;
  } fetch_word_t;

endpackage

`default_nettype wire

// ==== vic_bus_macros.svh ====
// ************************************************
// vic bus constants
// pal cycle and raster geometry, dma window and
// cpu register indices
// ************************************************
`ifndef VIC_BUS_MACROS_SVH
`define VIC_BUS_MACROS_SVH

// phi timing, 4 clocks low then 4 high
`define VIC_TICKS_PER_PHI 8

// pal line and frame geometry
`define VIC_CYCLES_PER_LINE 63
`define VIC_LINES_PER_FRAME 312

// raster range where badlines may occur
`define VIC_FIRST_DMA_LINE 48
`define VIC_LAST_DMA_LINE  247

// c-access window in cycles, ba drops this many cycles ahead
`define VIC_FETCH_FIRST 15
`define VIC_FETCH_LAST  54
`define VIC_BA_LEAD     3

// register indices on adl
`define VIC_REG_CTRL   'h11
`define VIC_REG_RASTER 'h12
`define VIC_REG_MEMPTR 'h18
`define VIC_REG_BORDER 'h20

`endif
